// File: div_pkg.sv
/* Widths, vector types, request format and phase encoding of the iterative divider.
   Every divider module imports this package by wildcard in its header */
package div_pkg;

   localparam int XLEN       = 32;
   localparam int EXT_W      = XLEN + 1;   // One guard bit for the sign
   localparam int COUNT_W    = 6;
   localparam int QUOT_STEPS = XLEN;       // One quotient bit per cycle

   // Operands and results
   typedef logic [XLEN-1:0]    xlen_t;

   // Partial remainder, divisor and shifting quotient
   typedef logic [EXT_W-1:0]   ext_t;

   typedef logic [COUNT_W-1:0] count_t;

   // One divide request as presented with the start strobe
   typedef struct packed {
      xlen_t dividend;
      xlen_t divisor;
      logic  unsign;   // Both operands unsigned
      logic  rem;      // Return remainder instead of quotient
   } div_req_t;

   // Sequencer phases
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      ITER   = 2'b01,   // One quotient bit per cycle
      REMFIX = 2'b10    // Final add-back for a negative remainder
   } div_phase_e;

   // Two's complement of an operand-wide value
   function automatic xlen_t neg_xlen(xlen_t v);
      return ~v + 1'b1;
   endfunction

endpackage

// File: div_ctrl.sv
/* Divider sequencer. Accepts a start strobe while idle, steps through the
   ITER and REMFIX phases and reports busy and done to the outside */
`timescale 1ns/1ps

module div_ctrl
   import div_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       start,
   input  logic       flush,
   input  logic       req_rem,
   output logic       load,
   output div_phase_e phase,
   output logic       first_step,
   output logic       rem_op,
   output logic       busy,
   output logic       done
);

   div_phase_e phase_nxt;
   count_t     count;
   logic       last_step;

   assign busy = (phase != IDLE);

   // A flush in the same cycle cancels the new request as well
   assign load = start & ~busy & ~flush;

   assign first_step = (phase == ITER) && (count == '0);
   assign last_step  = (phase == ITER) && (count == count_t'(QUOT_STEPS - 1));

   // Quotient finishes on the last step, remainder one cycle later
   assign done = ~flush & ((last_step & ~rem_op) | (phase == REMFIX));

   always_comb begin
      phase_nxt = phase;
      case (phase)
         IDLE: begin
            if (load) begin
               phase_nxt = ITER;
            end
         end
         ITER: begin
            if (last_step) begin
               phase_nxt = rem_op ? REMFIX : IDLE;
            end
         end
         REMFIX: begin
            phase_nxt = IDLE;   // Always a single cycle
         end
         default: begin
            phase_nxt = IDLE;
         end
      endcase

      // Cancel whatever is running
      if (flush) begin
         phase_nxt = IDLE;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         phase <= IDLE;
      end else begin
         phase <= phase_nxt;
      end
   end

   // Iteration count, stops at QUOT_STEPS once the steps are through
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else if (load) begin
         count <= '0;
      end else if (phase == ITER) begin
         count <= count + 1'b1;
      end
   end

   // Remainder flag held for the whole operation
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rem_op <= 1'b0;
      end else if (load) begin
         rem_op <= req_rem;
      end
   end

   a_count_range: assert property (@(posedge clk) disable iff (!arst_n)
      count <= count_t'(QUOT_STEPS))
      else $error("iteration count beyond %0d", QUOT_STEPS);

   // Done only while busy, and busy drops right after it
   a_done_ends_busy: assert property (@(posedge clk) disable iff (!arst_n)
      done |=> $fell(busy))
      else $error("done without busy falling on the next edge");

   a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
      start |-> !busy)
      else $error("start while busy is ignored");

endmodule

// File: div_datapath.sv
/* Non-restoring divide datapath holding the quotient, partial remainder and divisor.
   Loads on load, steps once per ITER cycle and adds the divisor back in REMFIX */
`timescale 1ns/1ps

module div_datapath
   import div_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       load,
   input  logic       first_step,
   input  div_phase_e phase,
   input  div_req_t   req,
   input  logic       neg_dividend,
   input  logic       divisor_compl,
   input  logic       sign_active,
   output xlen_t      raw_quot,
   output xlen_t      raw_rem
);

   // Dividend bits leave at the top, quotient bits enter at the bottom
   ext_t  q_ff;
   ext_t  a_ff;       // Partial remainder, two's complement
   ext_t  m_ff;       // Divisor, sign bit settled in the first step
   ext_t  q_eff;
   ext_t  m_eff;
   ext_t  a_base;
   ext_t  addend;
   ext_t  a_sum;
   xlen_t dividend_mag;
   logic  iter;
   logic  fix;
   logic  add;

   assign iter = (phase == ITER);
   assign fix  = (phase == REMFIX);

   // Magnitude of a negative signed dividend, used once before the first shift
   assign dividend_mag = neg_xlen(q_ff[EXT_W-1:1]);
   assign q_eff        = (first_step && neg_dividend) ? {dividend_mag, q_ff[0]} : q_ff;

   // Sign extension only for a signed op with a nonzero divisor
   assign m_eff = first_step ? {sign_active & m_ff[XLEN-1], m_ff[XLEN-1:0]} : m_ff;

   /* Subtract while the remainder is non-negative, add while negative.
      A negative divisor already carries its sign, so the choice flips */
   assign add = (fix | a_ff[XLEN]) ^ divisor_compl;

   // Shift the next dividend bit in, except in the add-back cycle
   assign a_base = fix ? a_ff : {a_ff[XLEN-1:0], q_eff[XLEN]};
   assign addend = add ? m_eff : ~m_eff;
   assign a_sum  = a_base + addend + {{XLEN{1'b0}}, ~add};   // Carry-in completes the subtract

   always_ff @(posedge clk) begin
      if (load) begin
         q_ff <= {req.dividend, 1'b0};
         a_ff <= '0;
         m_ff <= {1'b0, req.divisor};
      end else if (iter) begin
         q_ff <= {q_eff[XLEN-1:0], ~a_sum[XLEN]};   // New bit is the inverted sign
         a_ff <= a_sum;
         if (first_step) begin
            m_ff <= m_eff;
         end
      end else if (fix && a_ff[XLEN]) begin
         a_ff <= a_sum;   // Negative remainder gets the divisor back
      end
   end

   assign raw_quot = q_ff[XLEN-1:0];
   assign raw_rem  = a_ff[XLEN-1:0];

   a_phase_legal: assert property (@(posedge clk) disable iff (!arst_n)
      phase inside {IDLE, ITER, REMFIX})
      else $error("phase outside its encoding");

endmodule

// File: div_sign_fix.sv
/* Sign handling of the divider. Captures the operand signs at load, steers the
   datapath and turns the raw quotient or remainder into the signed result */
`timescale 1ns/1ps

module div_sign_fix
   import div_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     load,
   input  div_req_t req,
   input  logic     rem_op,
   input  xlen_t    raw_quot,
   input  xlen_t    raw_rem,
   output logic     neg_dividend,
   output logic     divisor_compl,
   output logic     sign_active,
   output xlen_t    result
);

   logic  dividend_neg_ff;
   logic  divisor_neg_ff;
   logic  sign_ff;          // Signed op with nonzero divisor
   logic  quot_neg;
   xlen_t quot_fix;
   xlen_t rem_fix;

   // Division by zero runs unsigned, giving all ones and the dividend
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dividend_neg_ff <= 1'b0;
         divisor_neg_ff  <= 1'b0;
         sign_ff         <= 1'b0;
      end else if (load) begin
         dividend_neg_ff <= req.dividend[XLEN-1];
         divisor_neg_ff  <= req.divisor[XLEN-1];
         sign_ff         <= ~req.unsign & (req.divisor != '0);
      end
   end

   assign sign_active   = sign_ff;
   assign neg_dividend  = sign_ff & dividend_neg_ff;
   assign divisor_compl = sign_ff & divisor_neg_ff;

   // Quotient negative when the signs differ
   assign quot_neg = sign_ff & (dividend_neg_ff ^ divisor_neg_ff);
   assign quot_fix = quot_neg ? neg_xlen(raw_quot) : raw_quot;

   // Remainder takes the sign of the dividend
   assign rem_fix = neg_dividend ? neg_xlen(raw_rem) : raw_rem;

   assign result = rem_op ? rem_fix : quot_fix;

endmodule

// File: div_top.sv
/* Top level of the 32-bit iterative divider with start, flush, busy and done.
   Ties the sequencer, the datapath and the sign unit together */
`timescale 1ns/1ps

module div_top
   import div_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     start,
   input  div_req_t req,
   input  logic     flush,
   output logic     busy,
   output logic     done,
   output xlen_t    result
);

   logic       load;
   logic       first_step;
   logic       rem_op;
   div_phase_e phase;
   logic       neg_dividend;
   logic       divisor_compl;
   logic       sign_active;
   xlen_t      raw_quot;
   xlen_t      raw_rem;

   div_ctrl u_ctrl (
      .clk        (clk),
      .arst_n     (arst_n),
      .start      (start),
      .flush      (flush),
      .req_rem    (req.rem),
      .load       (load),
      .phase      (phase),
      .first_step (first_step),
      .rem_op     (rem_op),
      .busy       (busy),
      .done       (done)
   );

   div_datapath u_datapath (
      .clk           (clk),
      .arst_n        (arst_n),
      .load          (load),
      .first_step    (first_step),
      .phase         (phase),
      .req           (req),
      .neg_dividend  (neg_dividend),
      .divisor_compl (divisor_compl),
      .sign_active   (sign_active),
      .raw_quot      (raw_quot),
      .raw_rem       (raw_rem)
   );

   div_sign_fix u_sign_fix (
      .clk           (clk),
      .arst_n        (arst_n),
      .load          (load),
      .req           (req),
      .rem_op        (rem_op),
      .raw_quot      (raw_quot),
      .raw_rem       (raw_rem),
      .neg_dividend  (neg_dividend),
      .divisor_compl (divisor_compl),
      .sign_active   (sign_active),
      .result        (result)
   );

endmodule

// File: tb_div_model.svh
/* Reference model for the divider testbench, RISC-V divide and remainder rules
   plus the Fibonacci LFSR that feeds the random operands */
`ifndef TB_DIV_MODEL_SVH
`define TB_DIV_MODEL_SVH

// Expected quotient or remainder for one request
function automatic logic [31:0] ref_divide(input logic [31:0] a, input logic [31:0] b,
                                           input logic uns, input logic rem);
   logic signed [31:0] sa;
   logic signed [31:0] sb;
   sa = a;
   sb = b;
   if (b == 32'd0) begin
      return rem ? a : 32'hffff_ffff;   // Divide by zero
   end
   if (uns) begin
      return rem ? (a % b) : (a / b);
   end
   if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      return rem ? 32'd0 : a;           // Signed overflow
   end
   // SV signed division truncates toward zero, as RISC-V does
   return rem ? 32'(sa % sb) : 32'(sa / sb);
endfunction

// One step of a 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   logic fb;
   fb = s[31] ^ s[21] ^ s[1] ^ s[0];
   return {s[30:0], fb};
endfunction

`endif

// File: tb_div.sv
/* Testbench for the 32-bit iterative divider. Runs random, corner and flush
   requests against a reference model, with assertions doing the checks */
`timescale 1ns/1ps

module tb_div
   import div_pkg::*;
;

   `include "tb_div_model.svh"

   localparam time CLK_PERIOD = 8ns;
   localparam int  RESET_CYCLES = 8;
   localparam int  N_UNSIGNED = 40;
   localparam int  N_SIGNED = 40;
   localparam int  N_CORNER = 8;
   localparam int  N_FLUSH = 8;
   localparam int  NUM_TESTS = N_UNSIGNED + N_SIGNED + N_CORNER + N_FLUSH;
   localparam int  WATCHDOG_CYCLES = NUM_TESTS * 40 + 100;
   localparam logic [31:0] LFSR_SEED = 32'd6143;

   logic     clk;
   logic     arst_n;
   logic     start;
   logic     flush;
   div_req_t req;
   logic     busy;
   logic     done;
   xlen_t    result;

   logic [31:0] lfsr_state;
   logic        started;        // Some request was accepted
   logic        active;         // Request in flight
   logic        result_valid;   // Result must hold the expected value
   int          cyc;
   int          exp_lat;
   xlen_t       exp_result;

   div_top uut (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (start),
      .req    (req),
      .flush  (flush),
      .busy   (busy),
      .done   (done),
      .result (result)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic fail_msg(input string what);
      $display("Failure at %0t: %s", $time, what);
      $display("Checks failed");
      $fatal(1);
   endtask

   // Takes n bits, one LFSR step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // Expected timing of each request, counted from the accepted start
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         started      <= 1'b0;
         active       <= 1'b0;
         result_valid <= 1'b0;
         cyc          <= 0;
         exp_lat      <= 0;
         exp_result   <= '0;
      end else if (start && !busy && !flush) begin
         started      <= 1'b1;
         active       <= 1'b1;
         result_valid <= 1'b0;
         cyc          <= 1;
         exp_lat      <= req.rem ? 33 : 32;
         exp_result   <= ref_divide(req.dividend, req.divisor, req.unsign, req.rem);
      end else if (active) begin
         cyc <= cyc + 1;
         if (done || flush) begin
            active <= 1'b0;
         end
         if (done) begin
            result_valid <= 1'b1;
         end
      end
   end

   a_idle_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
      !started |-> (!busy && !done))
      else fail_msg("busy or done before the first start");

   a_done_latency: assert property (@(posedge clk) disable iff (!arst_n)
      done |-> (active && cyc == exp_lat))
      else fail_value("done latency", 32'($sampled(exp_lat)), 32'($sampled(cyc)));

   a_busy_held: assert property (@(posedge clk) disable iff (!arst_n)
      busy == active)
      else fail_msg("busy does not follow the running request");

   a_flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
      flush |=> !busy)
      else fail_msg("busy still high after flush");

   a_flush_no_done: assert property (@(posedge clk) disable iff (!arst_n)
      flush |-> !done)
      else fail_msg("done during flush");

   a_result_value: assert property (@(posedge clk) disable iff (!arst_n)
      result_valid |-> (result == exp_result))
      else fail_value("result", $sampled(exp_result), $sampled(result));

   task automatic launch(input div_req_t r);
      @(posedge clk);
      start <= 1'b1;
      req   <= r;
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic do_divide(input div_req_t r);
      launch(r);
      do begin
         @(negedge clk);
      end while (!done);
      repeat (1 + int'(rand_bits(2))) @(posedge clk);   // Result hold window
   endtask

   // Flush k cycles into a request
   task automatic do_flush(input div_req_t r, input int k);
      launch(r);
      repeat (k) @(posedge clk);
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
      repeat (2) @(posedge clk);
   endtask

   function automatic div_req_t make_req(input logic [31:0] a, input logic [31:0] b,
                                         input logic uns, input logic rem);
      div_req_t r;
      r.dividend = a;
      r.divisor  = b;
      r.unsign   = uns;
      r.rem      = rem;
      return r;
   endfunction

   // Positive divisor of varying size, never zero
   function automatic logic [31:0] rand_divisor();
      logic [31:0] mag;
      mag = rand_bits(31) >> rand_bits(5);
      return mag | 32'd1;
   endfunction

   initial begin
      logic [31:0] a;
      logic [31:0] b;
      int          k;
      start      = 1'b0;
      flush      = 1'b0;
      req        = '0;
      arst_n     = 1'b0;
      lfsr_state = LFSR_SEED;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
      repeat (6) @(posedge clk);   // Idle, busy and done must stay low

      for (int i = 0; i < N_UNSIGNED; i++) begin
         a = rand_bits(32);
         b = rand_divisor();
         do_divide(make_req(a, b, 1'b1, i[0]));
      end

      // All four sign combinations in turn
      for (int i = 0; i < N_SIGNED; i++) begin
         a = rand_bits(32);
         a[31] = i[1];
         b = rand_divisor();
         if (i[2]) begin
            b = ~b + 32'd1;
         end
         do_divide(make_req(a, b, 1'b0, i[0]));
      end

      for (int i = 0; i < 4; i++) begin
         do_divide(make_req(rand_bits(32), 32'd0, i[1], i[0]));
         do_divide(make_req(32'h8000_0000, 32'hffff_ffff, i[1], i[0]));
      end

      // Odd passes flush in the very cycle that would raise done
      for (int i = 0; i < N_FLUSH / 2; i++) begin
         if (i[0]) begin
            k = QUOT_STEPS - 1 + int'(i[1]);
         end else begin
            k = 1 + int'(rand_bits(4));
         end
         do_flush(make_req(rand_bits(32), rand_divisor(), i[0], i[1]), k);
         do_divide(make_req(rand_bits(32), rand_divisor(), i[0], ~i[1]));
      end

      repeat (3) @(posedge clk);
      $display("All checks passed");
      $finish;
   end

   initial begin
      repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
      fail_msg("watchdog timeout, the divider stopped answering");
   end

endmodule

// File: flist.f
+incdir+.
div_pkg.sv
div_ctrl.sv
div_datapath.sv
div_sign_fix.sv
div_top.sv
tb_div.sv

// File: run.sh
#!/bin/sh
# Build the divider testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module tb_div -o tb_div_sim &&
./obj_dir/tb_div_sim | grep -q "All checks passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
